//--- build.f
hdl/cnn_cfg_pkg.sv
hdl/cfg_decoder.sv
hdl/cfg_fifo.sv
hdl/layer_sequencer.sv
hdl/layer_cfg_top.sv
sim/layer_cfg_props.sv
sim/layer_cfg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator from build.f, run, and look for the pass line.
# The error limit keeps the run going after an assertion failure.
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module layer_cfg_tb -f build.f &&
./obj_dir/Vlayer_cfg_tb +verilator+error+limit+1000 | tee /dev/stderr |
    grep -x "test passed" > /dev/null &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

//--- sim/layer_cfg_tb.sv
/* Expected records come from a queue model fed by an LFSR. Tests assume the
   queue is drained between them; layers stay at or under 256 blocks. */
`timescale 1ns/100ps

module layer_cfg_tb;

    localparam int cfg_depth_log2 = 3;
    localparam int queue_depth    = 1 << cfg_depth_log2;
    // Six tests, at most 16 layers each, 256 blocks plus overhead per layer
    localparam int timeout_cycles = 6 * 16 * 260;

    logic                                   clk         = 1'b0;
    logic                                   reset       = 1'b1;
    logic                                   cfg_val     = 1'b0;
    logic [cnn_cfg_pkg::cfg_word_width-1:0] cfg_word    = '0;
    logic                                   layer_start = 1'b0;
    cnn_cfg_pkg::layer_cfg_t                cur_cfg;
    logic                                   layer_busy;
    logic                                   blk_val;
    logic [cnn_cfg_pkg::count_width-1:0]    blk_idx;
    logic [cnn_cfg_pkg::count_width-1:0]    pat_idx;
    logic                                   layer_done;
    logic                                   missing_cfg;
    logic                                   cfg_overflow;
    logic                                   cfg_rejected;

    logic [31:0]             lfsr = 32'h4dfe1289;
    cnn_cfg_pkg::layer_cfg_t exp_q [$];
    string                   test_name;
    int                      test_errors;
    int                      assert_base;
    int                      tests_passed = 0;
    int                      tests_failed = 0;
    int                      cycle_count  = 0;

    layer_cfg_top #(.cfg_depth_log2(cfg_depth_log2)) dut_i (.*);

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: no finish after %0d cycles", timeout_cycles);
            $display("test failed");
            $finish;
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Fields drawn one by one, word packed msb first with zero reserved bits
    task automatic make_word(output logic [31:0] w, output cnn_cfg_pkg::layer_cfg_t rec);
        rec.len_row          = 4'(draw_bits(4));
        rec.dep_blk          = 4'(draw_bits(4));
        rec.num_blk          = 4'(draw_bits(4));
        rec.num_frm          = 4'(draw_bits(4));
        rec.num_pat          = 4'(draw_bits(4));
        rec.num_lay          = 4'(draw_bits(4));
        rec.pool.pool_en     = 1'(draw_bits(1));
        rec.pool.pool_kernel = 2'(draw_bits(2));
        w = {5'b0, rec.len_row, rec.dep_blk, rec.num_blk, rec.num_frm, rec.num_pat,
             rec.num_lay, rec.pool.pool_en, rec.pool.pool_kernel};
    endtask

    // One strobe cycle, entered and left on a falling edge
    task automatic send_word(input logic [31:0] w);
        cfg_val  = 1'b1;
        cfg_word = w;
        @(negedge clk);
        cfg_val  = 1'b0;
    endtask

    task automatic send_good();
        logic [31:0]             w;
        cnn_cfg_pkg::layer_cfg_t rec;
        make_word(w, rec);
        send_word(w);
        // Queued only while the FIFO has room
        if (exp_q.size() < queue_depth) begin
            exp_q.push_back(rec);
        end
    endtask

    // ==================================================
    // Checking helpers
    // ==================================================

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s %s expected %0h actual %0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        assert_base = dut_i.props_i.assert_fails;
    endtask

    task automatic end_test();
        int asserts;
        asserts = dut_i.props_i.assert_fails - assert_base;
        if (asserts != 0) begin
            $display("%s: %0d assertion failures", test_name, asserts);
        end
        if (test_errors + asserts == 0) begin
            tests_passed++;
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errors + asserts);
        end
    endtask

    // Start one layer and follow its walk; optional start pulse while busy
    task automatic run_layer(input logic poke_busy);
        cnn_cfg_pkg::layer_cfg_t exp_cfg;
        int                      exp_blocks;
        int                      blocks;
        int                      dones;
        logic [3:0]              b;
        logic [3:0]              p;
        exp_cfg     = exp_q.pop_front();
        exp_blocks  = (exp_cfg.num_pat + 1) * (exp_cfg.num_blk + 1);
        blocks      = 0;
        dones       = 0;
        b           = '0;
        p           = '0;
        layer_start = 1'b1;
        @(negedge clk);
        while (layer_busy) begin
            // Extra start during the first block
            layer_start = poke_busy && (blocks == 0);
            check_value("blk_val", 1, 32'(blk_val));
            check_value("cur_cfg", 32'(exp_cfg), 32'(cur_cfg));
            check_value("blk_idx", 32'(b), 32'(blk_idx));
            check_value("pat_idx", 32'(p), 32'(pat_idx));
            check_value("layer_done", 32'(blocks == exp_blocks - 1), 32'(layer_done));
            dones += int'(layer_done);
            blocks++;
            // Block index wraps into the next patch
            if (b == exp_cfg.num_blk) begin
                b = '0;
                p++;
            end else begin
                b++;
            end
            @(negedge clk);
        end
        layer_start = 1'b0;
        // No strobe once the layer has ended
        check_value("blk_val", 0, 32'(blk_val));
        check_value("blocks", exp_blocks, blocks);
        check_value("done pulses", 1, dones);
    endtask

    // ==================================================
    // Tests
    // ==================================================

    initial begin
        logic [31:0]             w;
        cnn_cfg_pkg::layer_cfg_t rec;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        start_test("1 order and fields");
        repeat (5) send_good();
        // Two cycles until the FIFO shows the last word
        repeat (2) @(negedge clk);
        repeat (5) run_layer(1'b0);
        end_test();

        start_test("2 block walk");
        repeat (3) send_good();
        repeat (2) @(negedge clk);
        repeat (3) run_layer(1'b0);
        end_test();

        start_test("3 empty start");
        layer_start = 1'b1;
        @(negedge clk);
        layer_start = 1'b0;
        check_value("missing_cfg", 1, 32'(missing_cfg));
        check_value("layer_busy", 0, 32'(layer_busy));
        @(negedge clk);
        check_value("missing_cfg", 0, 32'(missing_cfg));
        check_value("layer_busy", 0, 32'(layer_busy));
        end_test();

        start_test("4 overflow");
        check_value("cfg_overflow", 0, 32'(cfg_overflow));
        repeat (10) send_good();
        repeat (2) @(negedge clk);
        check_value("cfg_overflow", 1, 32'(cfg_overflow));
        repeat (queue_depth) run_layer(1'b0);
        end_test();

        start_test("5 reject");
        make_word(w, rec);
        // Any nonzero reserved field
        w[31:27] = 5'(draw_bits(5)) | 5'b00001;
        send_word(w);
        send_good();
        repeat (2) @(negedge clk);
        check_value("cfg_rejected", 1, 32'(cfg_rejected));
        run_layer(1'b0);
        end_test();

        start_test("6 busy start");
        repeat (2) send_good();
        repeat (2) @(negedge clk);
        run_layer(1'b1);
        run_layer(1'b0);
        end_test();

        $display("closing: %0d passed, %0d failed, %0d assertion failures",
                 tests_passed, tests_failed, dut_i.props_i.assert_fails);
        if (tests_failed == 0 && dut_i.props_i.assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim/layer_cfg_props.sv
/* Off while reset is high. Bound into layer_cfg_top so that both the FIFO
   and the sequencer side of the queue are in view. */
`timescale 1ns/100ps

module layer_cfg_props (
    input logic                    clk,
    input logic                    reset,
    input logic                    push,
    input logic                    full,
    input logic                    pop,
    input logic                    empty,
    input logic                    blk_val,
    input logic                    layer_busy,
    input logic                    layer_done,
    input cnn_cfg_pkg::layer_cfg_t cur_cfg
);

    // Failure count, read back by the testbench
    int assert_fails = 0;

    // ==================================================
    // Block walk
    // ==================================================

    blk_in_layer: assert property (@(posedge clk) disable iff (reset) blk_val |-> layer_busy)
        else begin
            $error("block strobe outside a running layer");
            assert_fails++;
        end

    done_on_blk: assert property (@(posedge clk) disable iff (reset) layer_done |-> blk_val)
        else begin
            $error("layer done without a block strobe");
            assert_fails++;
        end

    // Record may only change on a pop, never mid layer
    cfg_steady: assert property (@(posedge clk) disable iff (reset)
        (layer_busy && !layer_done) |=> $stable(cur_cfg))
        else begin
            $error("active configuration changed during a layer");
            assert_fails++;
        end

    idle_after_done: assert property (@(posedge clk) disable iff (reset)
        layer_done |=> !layer_busy)
        else begin
            $error("layer still busy after its done pulse");
            assert_fails++;
        end

    // ==================================================
    // Queue handshake
    // ==================================================

    no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else begin
            $error("push while the FIFO is full");
            assert_fails++;
        end

    no_pop_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else begin
            $error("pop while the FIFO is empty");
            assert_fails++;
        end

endmodule

bind layer_cfg_top layer_cfg_props props_i (.*);

//--- hdl/layer_cfg_top.sv
/* Queue depth is 2**cfg_depth_log2 records. Three cycles from a host strobe
   to the earliest block strobe; frame and layer counts pass through only. */
`timescale 1ns/100ps

module layer_cfg_top #(
    parameter int cfg_depth_log2 = 3
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   cfg_val,
    input  logic [cnn_cfg_pkg::cfg_word_width-1:0] cfg_word,
    input  logic                                   layer_start,
    output cnn_cfg_pkg::layer_cfg_t                cur_cfg,
    output logic                                   layer_busy,
    output logic                                   blk_val,
    output logic [cnn_cfg_pkg::count_width-1:0]    blk_idx,
    output logic [cnn_cfg_pkg::count_width-1:0]    pat_idx,
    output logic                                   layer_done,
    output logic                                   missing_cfg,
    output logic                                   cfg_overflow,
    output logic                                   cfg_rejected
);

    // ==================================================
    // Internal connections
    // ==================================================

    // Decoder to queue
    logic                    push;
    cnn_cfg_pkg::layer_cfg_t push_data;
    logic                    full;

    // Queue to sequencer
    cnn_cfg_pkg::layer_cfg_t head;
    logic                    empty;
    logic                    pop;

    // Host word check and push
    cfg_decoder decoder_i (
        .clk          (clk),
        .reset        (reset),
        .cfg_val      (cfg_val),
        .cfg_word     (cfg_word),
        .full         (full),
        .push         (push),
        .push_data    (push_data),
        .cfg_overflow (cfg_overflow),
        .cfg_rejected (cfg_rejected)
    );

    // Record queue
    cfg_fifo #(
        .payload_t  (cnn_cfg_pkg::layer_cfg_t),
        .depth_log2 (cfg_depth_log2)
    ) fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    // Layer run and block walk
    layer_sequencer sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .layer_start (layer_start),
        .head        (head),
        .empty       (empty),
        .pop         (pop),
        .cur_cfg     (cur_cfg),
        .layer_busy  (layer_busy),
        .blk_val     (blk_val),
        .blk_idx     (blk_idx),
        .pat_idx     (pat_idx),
        .layer_done  (layer_done),
        .missing_cfg (missing_cfg)
    );

endmodule

//--- hdl/layer_sequencer.sv
/* A start while a layer runs is ignored. A start with nothing queued only
   raises missing_cfg; counts follow the value plus one rule. */
`timescale 1ns/100ps

module layer_sequencer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                layer_start,
    input  cnn_cfg_pkg::layer_cfg_t             head,
    input  logic                                empty,
    output logic                                pop,
    output cnn_cfg_pkg::layer_cfg_t             cur_cfg,
    output logic                                layer_busy,
    output logic                                blk_val,
    output logic [cnn_cfg_pkg::count_width-1:0] blk_idx,
    output logic [cnn_cfg_pkg::count_width-1:0] pat_idx,
    output logic                                layer_done,
    output logic                                missing_cfg
);

    // ==================================================
    // State
    // ==================================================

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t state;

    // Walk position flags
    logic   is_idle;
    logic   last_in_pat;
    logic   last_blk;

    assign is_idle = (state == st_idle);

    // Take a record only when idle and one is waiting
    assign pop = layer_start && is_idle && !empty;

    // End of one patch, then end of the whole layer
    assign last_in_pat = (blk_idx == cur_cfg.num_blk);
    assign last_blk    = last_in_pat && (pat_idx == cur_cfg.num_pat);

    // ==================================================
    // Control FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (pop) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    // Back to idle after the final block
                    if (last_blk) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Active record, held for the whole layer
    always_ff @(posedge clk) begin
        if (pop) begin
            cur_cfg <= head;
        end
    end

    // ==================================================
    // Block and patch counters
    // ==================================================

    // Blocks inside patches, blk_idx wraps first
    always_ff @(posedge clk) begin
        if (reset) begin
            blk_idx <= '0;
            pat_idx <= '0;
        end else if (pop) begin
            blk_idx <= '0;
            pat_idx <= '0;
        end else if (blk_val) begin
            if (last_in_pat) begin
                blk_idx <= '0;
                pat_idx <= pat_idx + 1'b1;
            end else begin
                blk_idx <= blk_idx + 1'b1;
            end
        end
    end

    // One block strobe per running cycle
    assign layer_busy = !is_idle;
    assign blk_val    = layer_busy;
    assign layer_done = blk_val && last_blk;

    // Start seen with an empty queue
    always_ff @(posedge clk) begin
        if (reset) begin
            missing_cfg <= 1'b0;
        end else begin
            missing_cfg <= layer_start && is_idle && empty;
        end
    end

endmodule

//--- hdl/cfg_fifo.sv
/* Depth is a power of two. The caller must not push when full or pop when
   empty; neither condition is re-checked here. */
`timescale 1ns/100ps

module cfg_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  depth_log2 = 3
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    // ==================================================
    // Storage
    // ==================================================

    localparam int depth = 1 << depth_log2;

    // Register array, no reset on payload
    payload_t mem [depth];

    // Pointers carry one extra wrap bit
    logic [depth_log2:0]   wr_ptr;
    logic [depth_log2:0]   rd_ptr;

    // Array addresses
    logic [depth_log2-1:0] wr_addr;
    logic [depth_log2-1:0] rd_addr;

    assign wr_addr = wr_ptr[depth_log2-1:0];
    assign rd_addr = rd_ptr[depth_log2-1:0];

    // Write port
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_addr] <= push_data;
        end
    end

    // ==================================================
    // Pointer update
    // ==================================================

    // Push and pop may land in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ==================================================
    // Status and read data
    // ==================================================

    // Oldest entry, visible without a pop
    assign head = mem[rd_addr];

    // Same pointers means nothing held
    assign empty = (wr_ptr == rd_ptr);

    // Same address, different wrap bit
    assign full = (wr_addr == rd_addr) && (wr_ptr[depth_log2] != rd_ptr[depth_log2]);

endmodule

//--- hdl/cfg_decoder.sv
/* Host words are registered, then checked one cycle later. A word that finds
   the queue full is lost, and both error flags stay set until reset. */
`timescale 1ns/100ps

module cfg_decoder (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   cfg_val,
    input  logic [cnn_cfg_pkg::cfg_word_width-1:0] cfg_word,
    input  logic                                   full,
    output logic                                   push,
    output cnn_cfg_pkg::layer_cfg_t                push_data,
    output logic                                   cfg_overflow,
    output logic                                   cfg_rejected
);

    // ==================================================
    // Input stage
    // ==================================================

    logic                                   word_val_q;
    logic [cnn_cfg_pkg::cfg_word_width-1:0] word_q;
    logic                                   rsvd_bad;
    logic                                   word_good;

    // Strobe delayed by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            word_val_q <= 1'b0;
        end else begin
            word_val_q <= cfg_val;
        end
    end

    // Word payload, loaded on strobe only
    always_ff @(posedge clk) begin
        if (cfg_val) begin
            word_q <= cfg_word;
        end
    end

    // ==================================================
    // Check and push
    // ==================================================

    // Any reserved bit set marks a malformed word
    assign rsvd_bad  = |word_q[cnn_cfg_pkg::cfg_word_width-1 -: cnn_cfg_pkg::cfg_rsvd_width];
    assign word_good = word_val_q && !rsvd_bad;

    // Push only when the queue has room this cycle
    assign push      = word_good && !full;
    assign push_data = cnn_cfg_pkg::layer_cfg_t'(word_q[cnn_cfg_pkg::cfg_field_width-1:0]);

    // Sticky error flags
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_overflow <= 1'b0;
            cfg_rejected <= 1'b0;
        end else begin
            // Good word dropped on a full queue
            if (word_good && full) begin
                cfg_overflow <= 1'b1;
            end
            // Reserved bits nonzero, never queued
            if (word_val_q && rsvd_bad) begin
                cfg_rejected <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/cnn_cfg_pkg.sv
/* Layer configuration record and host word layout. Count fields hold the real
   count minus one, and the reserved bits above the record must be zero. */
package cnn_cfg_pkg;

    // ==================================================
    // Host word format
    // ==================================================

    // Host bus width, fixed by the word format
    localparam int cfg_word_width = 32;

    // Width of every count field
    // Field value plus one is the real count
    localparam int count_width = 4;

    // Pooling kernel select
    localparam int pool_kernel_width = 2;

    // ==================================================
    // Configuration records
    // ==================================================

    // Pooling control
    typedef struct packed {
        logic                         pool_en;
        logic [pool_kernel_width-1:0] pool_kernel;
    } pool_cfg_t;

    // One layer, msb first, same order as the host word
    typedef struct packed {
        logic [count_width-1:0] len_row;
        logic [count_width-1:0] dep_blk;
        logic [count_width-1:0] num_blk;
        logic [count_width-1:0] num_frm;
        logic [count_width-1:0] num_pat;
        logic [count_width-1:0] num_lay;
        pool_cfg_t              pool;
    } layer_cfg_t;

    // Record occupies the low bits of the word
    localparam int cfg_field_width = $bits(layer_cfg_t);

    // Reserved bits sit above the record
    localparam int cfg_rsvd_width = cfg_word_width - cfg_field_width;

endpackage
